// File: build.f
source/game_pkg.sv
source/raster_timing.sv
source/player_move_ctl.sv
source/player_render.sv
source/game_top.sv
bench/game_tb.sv

// File: Makefile
TOP := game_tb

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f build.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: bench/game_tb.sv
// ********************
// small 48x10 raster, one frame is 480 clocks
// reference model runs in lockstep with the DUT from reset
// inputs change on the rising edge, outputs compared every cycle
// ********************

`timescale 1ns/1ns

module game_tb;

    localparam int H_ACTIVE     = 40;
    localparam int H_TOTAL      = 48;
    localparam int V_ACTIVE     = 8;
    localparam int V_TOTAL      = 10;
    localparam int BLOCK_LEFT   = 10;
    localparam int BLOCK_RIGHT  = 20;
    localparam int X_MAX        = 30;
    localparam int PLAYER_W     = 2;
    localparam int PLAYER_Y     = 4;
    localparam int BLOCK_Y      = 2;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int TEST_FRAMES  = 130;  // script runs about 122 frames
    localparam int MAX_CYCLES   = (TEST_FRAMES + 5) * FRAME_CYCLES;

    logic                       clk;
    logic                       rst;
    logic                       m_left;
    logic                       m_right;
    logic                       gpio_left;
    logic                       gpio_right;
    logic [1:0]                 button_pressed;
    logic [game_pkg::RGB_W-1:0] rgb;
    logic                       de;
    logic [game_pkg::POS_W-1:0] xpos_player1;
    logic [game_pkg::POS_W-1:0] xpos_player2;
    game_pkg::move_state_t      state;

    // reference model state
    logic [game_pkg::POS_W-1:0] ref_h;
    logic [game_pkg::POS_W-1:0] ref_v;
    logic [5:0]                 key_d1;  // two stage input delay
    logic [5:0]                 key_d2;
    logic                       s_mr;
    logic                       s_ml;
    logic                       s_gr;
    logic                       s_gl;
    logic [1:0]                 s_climb;
    logic                       frame_edge;
    game_pkg::move_state_t      exp_state;
    logic [game_pkg::POS_W-1:0] exp_x1;
    logic [game_pkg::POS_W-1:0] exp_x2;
    logic [game_pkg::RGB_W-1:0] exp_rgb;
    logic                       exp_de;
    logic                       check_en = 1'b0;
    int                         frame_cnt;
    int                         cycle_cnt;
    int                         seed = 25180;
    string                      test_name = "reset";

    game_top #(
        .H_ACTIVE    (H_ACTIVE),
        .H_TOTAL     (H_TOTAL),
        .V_ACTIVE    (V_ACTIVE),
        .V_TOTAL     (V_TOTAL),
        .BLOCK_LEFT  (BLOCK_LEFT),
        .BLOCK_RIGHT (BLOCK_RIGHT),
        .X_MAX       (X_MAX),
        .PLAYER_W    (PLAYER_W),
        .PLAYER_Y    (PLAYER_Y),
        .BLOCK_Y     (BLOCK_Y)
    ) dut0 (
        .clk            (clk),
        .rst            (rst),
        .m_left         (m_left),
        .m_right        (m_right),
        .gpio_left      (gpio_left),
        .gpio_right     (gpio_right),
        .button_pressed (button_pressed),
        .rgb            (rgb),
        .de             (de),
        .xpos_player1   (xpos_player1),
        .xpos_player2   (xpos_player2),
        .state          (state)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // position after one walking frame, wall passable only with climb
    function automatic logic [game_pkg::POS_W-1:0] next_x(
        input int   x,
        input logic go_right,
        input logic climb
    );
        logic on_wall;
        on_wall = (x >= BLOCK_LEFT) && (x <= BLOCK_RIGHT);
        if (go_right) begin
            if (x >= X_MAX) return x;
            if (on_wall && !climb) return x;
            return x + 1;
        end
        if (x == 0) return x;
        if (on_wall && !climb && (x != BLOCK_LEFT)) return x;  // left face lets go
        return x - 1;
    endfunction

    // left walk is dropped strictly inside the wall
    function automatic logic inside_wall(input int x);
        return (x > BLOCK_LEFT) && (x < BLOCK_RIGHT);
    endfunction

    // priority p1, p2, block, sky
    function automatic logic [game_pkg::RGB_W-1:0] pixel_color(
        input int                    h,
        input int                    v,
        input int                    x1,
        input int                    x2,
        input game_pkg::move_state_t st
    );
        if ((v >= PLAYER_Y) && (h >= x1) && (h <= x1 + PLAYER_W - 1)) begin
            if ((st == game_pkg::RIGHT1) || (st == game_pkg::LEFT1)) begin
                return game_pkg::COLOR_P1_MOVE;
            end
            return game_pkg::COLOR_P1;
        end
        if ((v >= PLAYER_Y) && (h >= x2) && (h <= x2 + PLAYER_W - 1)) begin
            if ((st == game_pkg::RIGHT2) || (st == game_pkg::LEFT2)) begin
                return game_pkg::COLOR_P2_MOVE;
            end
            return game_pkg::COLOR_P2;
        end
        if ((v >= BLOCK_Y) && (h >= BLOCK_LEFT) && (h <= BLOCK_RIGHT)) begin
            return game_pkg::COLOR_BLOCK;
        end
        return game_pkg::COLOR_BG;
    endfunction

    assign s_mr       = key_d2[0];
    assign s_ml       = key_d2[1];
    assign s_gr       = key_d2[2];
    assign s_gl       = key_d2[3];
    assign s_climb    = key_d2[5:4];
    assign frame_edge = (ref_h == 0) && (ref_v == V_ACTIVE);  // first vblank clock

    // reference model
    always @(posedge clk) begin
        if (rst) begin
            ref_h     <= '0;
            ref_v     <= '0;
            key_d1    <= '0;
            key_d2    <= '0;
            exp_state <= game_pkg::IDLE;
            exp_x1    <= '0;
            exp_x2    <= '0;
            exp_rgb   <= '0;
            exp_de    <= 1'b0;
            check_en  <= 1'b1;  // reset values compared too
            frame_cnt <= 0;
        end else begin
            if (ref_h == H_TOTAL - 1) begin
                ref_h <= '0;
                ref_v <= (ref_v == V_TOTAL - 1) ? '0 : ref_v + 1'b1;
            end else begin
                ref_h <= ref_h + 1'b1;
            end
            key_d1 <= {button_pressed, gpio_left, gpio_right, m_left, m_right};
            key_d2 <= key_d1;
            if (frame_edge) begin
                frame_cnt <= frame_cnt + 1;
                case (exp_state)
                    game_pkg::IDLE: begin
                        if (s_mr) exp_state <= game_pkg::RIGHT1;
                        else if (s_ml) exp_state <= game_pkg::LEFT1;
                        else if (s_gr) exp_state <= game_pkg::RIGHT2;
                        else if (s_gl) exp_state <= game_pkg::LEFT2;
                    end
                    game_pkg::RIGHT1: begin
                        if (!s_mr) exp_state <= game_pkg::IDLE;
                        else exp_x1 <= next_x(exp_x1, 1'b1, s_climb[0]);
                    end
                    game_pkg::LEFT1: begin
                        if (!s_ml || (inside_wall(exp_x1) && !s_climb[0])) begin
                            exp_state <= game_pkg::IDLE;
                        end else begin
                            exp_x1 <= next_x(exp_x1, 1'b0, s_climb[0]);
                        end
                    end
                    game_pkg::RIGHT2: begin
                        if (!s_gr) exp_state <= game_pkg::IDLE;
                        else exp_x2 <= next_x(exp_x2, 1'b1, s_climb[1]);
                    end
                    game_pkg::LEFT2: begin
                        if (!s_gl || (inside_wall(exp_x2) && !s_climb[1])) begin
                            exp_state <= game_pkg::IDLE;
                        end else begin
                            exp_x2 <= next_x(exp_x2, 1'b0, s_climb[1]);
                        end
                    end
                    default: exp_state <= game_pkg::IDLE;
                endcase
            end
            if ((ref_h >= H_ACTIVE) || (ref_v >= V_ACTIVE)) begin
                exp_rgb <= '0;  // blanking is black
                exp_de  <= 1'b0;
            end else begin
                exp_rgb <= pixel_color(ref_h, ref_v, exp_x1, exp_x2, exp_state);
                exp_de  <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: test sequence did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    task automatic report_mismatch(
        input string       what,
        input logic [31:0] exp_val,
        input logic [31:0] act_val
    );
        $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp_val, act_val);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // milestone check on a settled output
    task automatic expect_value(input string what, input int exp_val, input int act_val);
        assert (exp_val == act_val)
        else report_mismatch(what, exp_val, act_val);
    endtask

    task automatic drive_keys(
        input logic       ml,
        input logic       mr,
        input logic       gl,
        input logic       gr,
        input logic [1:0] climb
    );
        @(posedge clk);
        m_left         <= ml;
        m_right        <= mr;
        gpio_left      <= gl;
        gpio_right     <= gr;
        button_pressed <= climb;
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frame_cnt + n;
        while (frame_cnt < target) @(posedge clk);
    endtask

    // per cycle comparison against the model
    a_rgb: assert property (@(posedge clk) check_en |-> (rgb == exp_rgb))
        else report_mismatch("rgb", $sampled(exp_rgb), $sampled(rgb));
    a_de: assert property (@(posedge clk) check_en |-> (de == exp_de))
        else report_mismatch("de", $sampled(exp_de), $sampled(de));
    a_x1: assert property (@(posedge clk) check_en |-> (xpos_player1 == exp_x1))
        else report_mismatch("xpos_player1", $sampled(exp_x1), $sampled(xpos_player1));
    a_x2: assert property (@(posedge clk) check_en |-> (xpos_player2 == exp_x2))
        else report_mismatch("xpos_player2", $sampled(exp_x2), $sampled(xpos_player2));
    a_state: assert property (@(posedge clk) check_en |-> (state == exp_state))
        else report_mismatch("state", $sampled(exp_state), $sampled(state));

    initial begin
        int hold;
        rst            = 1'b1;
        m_left         = 1'b0;
        m_right        = 1'b0;
        gpio_left      = 1'b0;
        gpio_right     = 1'b0;
        button_pressed = 2'b00;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        wait_frames(1);  // both players overlap at 0

        test_name = "p1_walk_right";
        drive_keys(1'b0, 1'b1, 1'b0, 1'b0, 2'b00);
        wait_frames(13);  // entry, 10 steps, 2 against the wall
        expect_value("xpos_player1 at wall", BLOCK_LEFT, xpos_player1);
        drive_keys(1'b0, 1'b1, 1'b0, 1'b0, 2'b01);  // climb over
        wait_frames(22);
        expect_value("xpos_player1 at edge", X_MAX, xpos_player1);

        test_name = "p1_walk_left";
        drive_keys(1'b1, 1'b0, 1'b0, 1'b0, 2'b00);
        wait_frames(14);  // idle, entry, 10 steps, 2 held
        expect_value("xpos_player1 at wall", BLOCK_RIGHT, xpos_player1);
        drive_keys(1'b1, 1'b0, 1'b0, 1'b0, 2'b01);
        wait_frames(22);
        expect_value("xpos_player1 at edge", 0, xpos_player1);
        drive_keys(1'b0, 1'b0, 1'b0, 1'b0, 2'b00);
        wait_frames(1);
        expect_value("state after release", game_pkg::IDLE, state);

        test_name = "p2_gpio";
        drive_keys(1'b0, 1'b0, 1'b0, 1'b1, 2'b00);
        wait_frames(13);
        expect_value("xpos_player2 at wall", BLOCK_LEFT, xpos_player2);
        drive_keys(1'b0, 1'b0, 1'b0, 1'b1, 2'b10);  // five steps onto the wall
        wait_frames(5);
        drive_keys(1'b0, 1'b0, 1'b0, 1'b1, 2'b00);
        wait_frames(2);  // stuck on the wall
        drive_keys(1'b0, 1'b0, 1'b1, 1'b0, 2'b00);
        wait_frames(4);  // left walk dropped inside the wall
        expect_value("xpos_player2 inside wall", 15, xpos_player2);
        drive_keys(1'b0, 1'b0, 1'b1, 1'b0, 2'b10);
        wait_frames(5);  // climb back to the left face
        expect_value("xpos_player2 at left face", BLOCK_LEFT, xpos_player2);
        drive_keys(1'b0, 1'b0, 1'b1, 1'b0, 2'b00);  // left face lets go without climb
        wait_frames(13);
        expect_value("xpos_player2 at edge", 0, xpos_player2);
        drive_keys(1'b0, 1'b0, 1'b0, 1'b0, 2'b00);
        wait_frames(1);

        // mouse beats gpio, then release mid walk
        test_name = "priority_release";
        hold = 2 + ($unsigned($random(seed)) % 3);
        drive_keys(1'b0, 1'b1, 1'b0, 1'b1, 2'b00);
        wait_frames(hold);
        expect_value("xpos_player2 not moved", 0, xpos_player2);
        drive_keys(1'b0, 1'b0, 1'b0, 1'b0, 2'b00);
        wait_frames(2);
        expect_value("state after release", game_pkg::IDLE, state);

        test_name = "done";
        repeat (4) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: source/game_top.sv
// ********************
// two player platform core, SVGA 800x600 raster by default
// no sync pulses, rgb/de go straight to the display
// ********************

`timescale 1ns/1ns

module game_top #(
    parameter int H_ACTIVE    = 800,
    parameter int H_TOTAL     = 1056,
    parameter int V_ACTIVE    = 600,
    parameter int V_TOTAL     = 628,
    parameter int BLOCK_LEFT  = 310,  // wall columns
    parameter int BLOCK_RIGHT = 450,
    parameter int X_MAX       = 660,  // right walking limit
    parameter int PLAYER_W    = 48,
    parameter int PLAYER_Y    = 440,
    parameter int BLOCK_Y     = 380
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       m_left,      // player 1, mouse buttons
    input  logic                       m_right,
    input  logic                       gpio_left,   // player 2, board buttons
    input  logic                       gpio_right,
    input  logic [1:0]                 button_pressed,
    output logic [game_pkg::RGB_W-1:0] rgb,
    output logic                       de,
    output logic [game_pkg::POS_W-1:0] xpos_player1,
    output logic [game_pkg::POS_W-1:0] xpos_player2,
    output game_pkg::move_state_t      state
);

    logic [game_pkg::POS_W-1:0] hcount;
    logic [game_pkg::POS_W-1:0] vcount;
    logic                       hblank;
    logic                       vblank;

    raster_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) u_timing (
        .clk    (clk),
        .rst    (rst),
        .hcount (hcount),
        .vcount (vcount),
        .hblank (hblank),
        .vblank (vblank)
    );

    // vblank doubles as the frame tick
    player_move_ctl #(
        .BLOCK_LEFT  (BLOCK_LEFT),
        .BLOCK_RIGHT (BLOCK_RIGHT),
        .X_MAX       (X_MAX)
    ) u_move (
        .clk            (clk),
        .rst            (rst),
        .vblank         (vblank),
        .m_left         (m_left),
        .m_right        (m_right),
        .gpio_left      (gpio_left),
        .gpio_right     (gpio_right),
        .button_pressed (button_pressed),
        .xpos_player1   (xpos_player1),
        .xpos_player2   (xpos_player2),
        .state          (state)
    );

    player_render #(
        .H_ACTIVE    (H_ACTIVE),
        .V_ACTIVE    (V_ACTIVE),
        .BLOCK_LEFT  (BLOCK_LEFT),
        .BLOCK_RIGHT (BLOCK_RIGHT),
        .BLOCK_Y     (BLOCK_Y),
        .PLAYER_W    (PLAYER_W),
        .PLAYER_Y    (PLAYER_Y)
    ) u_render (
        .clk          (clk),
        .rst          (rst),
        .hcount       (hcount),
        .vcount       (vcount),
        .hblank       (hblank),
        .vblank       (vblank),
        .xpos_player1 (xpos_player1),
        .xpos_player2 (xpos_player2),
        .state        (state),
        .rgb          (rgb),
        .de           (de)
    );

endmodule

// File: source/player_render.sv
// ********************
// flat colour boxes, players drawn down to the bottom of the screen
// one register stage, pixel out 1 cycle after its counters
// ********************

`timescale 1ns/1ns

module player_render #(
    parameter int H_ACTIVE    = 800,
    parameter int V_ACTIVE    = 600,
    parameter int BLOCK_LEFT  = 310,
    parameter int BLOCK_RIGHT = 450,
    parameter int BLOCK_Y     = 380,
    parameter int PLAYER_W    = 48,
    parameter int PLAYER_Y    = 440
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [game_pkg::POS_W-1:0] hcount,
    input  logic [game_pkg::POS_W-1:0] vcount,
    input  logic                       hblank,
    input  logic                       vblank,
    input  logic [game_pkg::POS_W-1:0] xpos_player1,
    input  logic [game_pkg::POS_W-1:0] xpos_player2,
    input  game_pkg::move_state_t      state,
    output logic [game_pkg::RGB_W-1:0] rgb,
    output logic                       de
);

    logic                       in_p1;
    logic                       in_p2;
    logic                       in_block;
    logic [game_pkg::RGB_W-1:0] pix_color;

    // hit tests for the current pixel
    assign in_p1 = (hcount >= xpos_player1) && (hcount < xpos_player1 + PLAYER_W)
                   && (vcount >= PLAYER_Y);
    assign in_p2 = (hcount >= xpos_player2) && (hcount < xpos_player2 + PLAYER_W)
                   && (vcount >= PLAYER_Y);
    assign in_block = (hcount >= BLOCK_LEFT) && (hcount <= BLOCK_RIGHT)
                      && (vcount >= BLOCK_Y);

    // p1 over p2 over block over sky
    always_comb begin
        if (in_p1) begin
            pix_color = (state == game_pkg::RIGHT1 || state == game_pkg::LEFT1) ?
                        game_pkg::COLOR_P1_MOVE : game_pkg::COLOR_P1;
        end else if (in_p2) begin
            pix_color = (state == game_pkg::RIGHT2 || state == game_pkg::LEFT2) ?
                        game_pkg::COLOR_P2_MOVE : game_pkg::COLOR_P2;
        end else if (in_block) begin
            pix_color = game_pkg::COLOR_BLOCK;
        end else begin
            pix_color = game_pkg::COLOR_BG;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb <= '0;
            de  <= 1'b0;
        end else if (hblank || vblank) begin
            rgb <= '0;  // black in blanking
            de  <= 1'b0;
        end else begin
            rgb <= pix_color;
            de  <= 1'b1;
        end
    end

    // nothing but black leaves while the display is not enabled
    a_blank_black: assert property (@(posedge clk) disable iff (rst)
        !de |-> (rgb == '0));

    // blank levels from the timing block agree with this module's active area
    a_blank_levels: assert property (@(posedge clk) disable iff (rst)
        (hblank == (hcount >= H_ACTIVE)) && (vblank == (vcount >= V_ACTIVE)));

endmodule

// File: source/player_move_ctl.sv
// ********************
// inputs are plain button levels, synchronized here (2 cycles)
// moves happen only on the rising edge of vblank, one pixel per frame
// one player moves at a time, mouse side has priority
// ********************

`timescale 1ns/1ns

module player_move_ctl #(
    parameter int BLOCK_LEFT  = 310,
    parameter int BLOCK_RIGHT = 450,
    parameter int X_MAX       = 660
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       vblank,
    input  logic                       m_left,
    input  logic                       m_right,
    input  logic                       gpio_left,
    input  logic                       gpio_right,
    input  logic [1:0]                 button_pressed,  // climb, bit 0 p1, bit 1 p2
    output logic [game_pkg::POS_W-1:0] xpos_player1,
    output logic [game_pkg::POS_W-1:0] xpos_player2,
    output game_pkg::move_state_t      state
);

    logic [5:0]                 sync_q1;  // first stage, may be metastable
    logic [5:0]                 sync_q2;
    logic                       m_left_s;
    logic                       m_right_s;
    logic                       gpio_left_s;
    logic                       gpio_right_s;
    logic [1:0]                 climb_s;
    logic                       vblank_prev;
    logic                       frame_edge;
    game_pkg::move_state_t      state_nxt;
    logic [game_pkg::POS_W-1:0] xpos_nxt1;
    logic [game_pkg::POS_W-1:0] xpos_nxt2;

    // one step to the right, wall only passable while climbing
    function automatic logic [game_pkg::POS_W-1:0] step_right(
        input logic [game_pkg::POS_W-1:0] x,
        input logic                       climb
    );
        if (x < BLOCK_LEFT) begin
            return x + 1'b1;  // before the wall
        end else if (x <= BLOCK_RIGHT) begin
            return climb ? x + 1'b1 : x;  // on the wall
        end else if (x < X_MAX) begin
            return x + 1'b1;  // past the wall
        end
        return x;  // screen edge
    endfunction

    // one step to the left
    function automatic logic [game_pkg::POS_W-1:0] step_left(
        input logic [game_pkg::POS_W-1:0] x,
        input logic                       climb
    );
        if (x == '0) begin
            return x;  // screen edge
        end else if (x <= BLOCK_LEFT) begin
            return x - 1'b1;  // left face always lets go
        end else if (x > BLOCK_RIGHT) begin
            return x - 1'b1;
        end
        return climb ? x - 1'b1 : x;  // right face holds without climb
    endfunction

    // strictly inside the wall without climb, walk is dropped
    function automatic logic stuck_left(
        input logic [game_pkg::POS_W-1:0] x,
        input logic                       climb
    );
        return !climb && (x > BLOCK_LEFT) && (x < BLOCK_RIGHT);
    endfunction

    assign m_left_s     = sync_q2[0];
    assign m_right_s    = sync_q2[1];
    assign gpio_left_s  = sync_q2[2];
    assign gpio_right_s = sync_q2[3];
    assign climb_s      = sync_q2[5:4];

    assign frame_edge = vblank && !vblank_prev;  // start of vertical blanking

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q1      <= '0;
            sync_q2      <= '0;
            vblank_prev  <= 1'b0;
            state        <= game_pkg::IDLE;
            xpos_player1 <= '0;
            xpos_player2 <= '0;
        end else begin
            sync_q1     <= {button_pressed, gpio_right, gpio_left, m_right, m_left};
            sync_q2     <= sync_q1;
            vblank_prev <= vblank;
            if (frame_edge) begin  // once per frame
                state        <= state_nxt;
                xpos_player1 <= xpos_nxt1;
                xpos_player2 <= xpos_nxt2;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        xpos_nxt1 = xpos_player1;
        xpos_nxt2 = xpos_player2;
        case (state)
            game_pkg::IDLE: begin
                // entry only, nobody moves on this edge
                if (m_right_s) begin
                    state_nxt = game_pkg::RIGHT1;
                end else if (m_left_s) begin
                    state_nxt = game_pkg::LEFT1;
                end else if (gpio_right_s) begin
                    state_nxt = game_pkg::RIGHT2;
                end else if (gpio_left_s) begin
                    state_nxt = game_pkg::LEFT2;
                end
            end
            game_pkg::RIGHT1: begin
                if (!m_right_s) begin
                    state_nxt = game_pkg::IDLE;  // key released
                end else begin
                    xpos_nxt1 = step_right(xpos_player1, climb_s[0]);
                end
            end
            game_pkg::LEFT1: begin
                if (!m_left_s || stuck_left(xpos_player1, climb_s[0])) begin
                    state_nxt = game_pkg::IDLE;
                end else begin
                    xpos_nxt1 = step_left(xpos_player1, climb_s[0]);
                end
            end
            game_pkg::RIGHT2: begin
                if (!gpio_right_s) begin
                    state_nxt = game_pkg::IDLE;
                end else begin
                    xpos_nxt2 = step_right(xpos_player2, climb_s[1]);
                end
            end
            game_pkg::LEFT2: begin
                if (!gpio_left_s || stuck_left(xpos_player2, climb_s[1])) begin
                    state_nxt = game_pkg::IDLE;
                end else begin
                    xpos_nxt2 = step_left(xpos_player2, climb_s[1]);
                end
            end
            default: state_nxt = game_pkg::IDLE;  // illegal codes recover
        endcase
    end

    // positions move only right after a frame edge, one pixel at most
    a_p1_step: assert property (@(posedge clk) disable iff (rst)
        $changed(xpos_player1) |-> $past(frame_edge) &&
            ((xpos_player1 == $past(xpos_player1) + 1'b1) ||
             (xpos_player1 == $past(xpos_player1) - 1'b1)));

    a_p2_step: assert property (@(posedge clk) disable iff (rst)
        $changed(xpos_player2) |-> $past(frame_edge) &&
            ((xpos_player2 == $past(xpos_player2) + 1'b1) ||
             (xpos_player2 == $past(xpos_player2) - 1'b1)));

    // nobody walks off the right side
    a_x_limit: assert property (@(posedge clk) disable iff (rst)
        (xpos_player1 <= X_MAX) && (xpos_player2 <= X_MAX));

endmodule

// File: source/raster_timing.sv
// ********************
// free running raster counters, no sync pulses
// blank levels are registered and line up with the counters
// ********************

`timescale 1ns/1ns

module raster_timing #(
    parameter int H_ACTIVE = 800,
    parameter int H_TOTAL  = 1056,
    parameter int V_ACTIVE = 600,
    parameter int V_TOTAL  = 628
) (
    input  logic                       clk,
    input  logic                       rst,
    output logic [game_pkg::POS_W-1:0] hcount,
    output logic [game_pkg::POS_W-1:0] vcount,
    output logic                       hblank,
    output logic                       vblank
);

    logic [game_pkg::POS_W-1:0] hcount_nxt;
    logic [game_pkg::POS_W-1:0] vcount_nxt;

    // next pixel position
    always_comb begin
        hcount_nxt = hcount + 1'b1;
        vcount_nxt = vcount;
        if (hcount == H_TOTAL - 1) begin  // end of line
            hcount_nxt = '0;
            if (vcount == V_TOTAL - 1) begin  // end of frame
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vcount + 1'b1;
            end
        end
    end

    // blank levels decoded from the next counts
    // so they match the counter value in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hblank <= 1'b0;
            vblank <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hblank <= (hcount_nxt >= H_ACTIVE);  // right border and retrace
            vblank <= (vcount_nxt >= V_ACTIVE);  // bottom border and retrace
        end
    end

    // counters never leave the raster
    a_count_range: assert property (@(posedge clk) disable iff (rst)
        (hcount < H_TOTAL) && (vcount < V_TOTAL));

endmodule

// File: source/game_pkg.sv
// ********************
// shared widths, FSM encoding and palette
// colours are 4 bits per channel, {r, g, b}
// ********************

package game_pkg;

    localparam int POS_W = 12;  // counters and player x positions
    localparam int RGB_W = 12;  // 4/4/4 colour word

    // which player moves and where, one at a time
    typedef enum logic [2:0] {
        IDLE,
        RIGHT1,
        LEFT1,
        RIGHT2,
        LEFT2
    } move_state_t;

    // palette
    localparam logic [RGB_W-1:0] COLOR_BG      = 12'h48c;  // sky
    localparam logic [RGB_W-1:0] COLOR_BLOCK   = 12'h631;  // brown wall
    localparam logic [RGB_W-1:0] COLOR_P1      = 12'hc00;
    localparam logic [RGB_W-1:0] COLOR_P1_MOVE = 12'hf88;  // lighter while walking
    localparam logic [RGB_W-1:0] COLOR_P2      = 12'h00c;
    localparam logic [RGB_W-1:0] COLOR_P2_MOVE = 12'h88f;

endpackage
